/* all.f */
+incdir+logic
logic/core_pkg.sv
logic/core_if.sv
logic/pipe_regs.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/data_mem.sv
logic/rv_core_top.sv
test/tb_clock.sv
test/tb_core.sv

/* logic/core_if.sv */
`include "core_params.svh"

// Operands and controls from ID/EX into the execute stage
interface ex_bus_if;
    import core_pkg::*;

    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] imm;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    alu_op_e          alu_op;
    ctrl_t            ctrl;

    modport source (
        output rs1_data, rs2_data, imm, rs1, rs2, rd, alu_op, ctrl
    );

    modport sink (
        input rs1_data, rs2_data, imm, rs1, rs2, rd, alu_op, ctrl
    );
endinterface

// Result of EX/MEM toward data memory and MEM/WB
interface mem_bus_if;
    import core_pkg::*;

    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] write_data;
    logic [4:0]       rd;
    ctrl_t            ctrl;

    modport source (
        output alu_result, write_data, rd, ctrl
    );

    modport sink (
        input alu_result, write_data, rd, ctrl
    );
endinterface

/* logic/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Operand and datapath width
`define XLEN 32

// Architectural registers including x0
`define REG_COUNT 32

// Data memory depth in 32-bit words
`define DMEM_WORDS 64

`endif

/* logic/core_pkg.sv */
package core_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011
    } instruction_format_type;

    typedef struct packed {
        logic [6:0]             funct7;
        logic [4:0]             rs2;
        logic [4:0]             rs1;
        logic [2:0]             funct3;
        logic [4:0]             rd;
        instruction_format_type opcode;
    } r_type_t;

    // I-type and S-type share this layout but split the immediate differently
    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [4:0]             rs2_or_imm_lo;
        logic [4:0]             rs1;
        logic [2:0]             funct3;
        logic [4:0]             rd_or_imm_lo;
        instruction_format_type opcode;
    } is_type_t;

    typedef union packed {
        r_type_t  r_view;
        is_type_t is_view;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic mem_write;
        logic mem2reg;
        logic reg_write;
        logic alu_src;
    } ctrl_t;

    // addi x0, x0, 0
    localparam instr_u NOOP = instr_u'(32'h0000_0013);

endpackage

/* logic/data_mem.sv */
`include "core_params.svh"

module data_mem (
    input  logic             clk,
    input  logic             i_rst,
    mem_bus_if.sink          bus,
    output logic [`XLEN-1:0] o_rd_data
);
    localparam int ADDR_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]  mem [`DMEM_WORDS];
    logic [ADDR_W-1:0] word_addr;

    // Byte address to word index modulo the memory size
    assign word_addr = bus.alu_result[ADDR_W+1:2];

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            for (int i = 0; i < `DMEM_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (bus.ctrl.mem_write)
        begin
            mem[word_addr] <= bus.write_data;
        end
    end

    assign o_rd_data = mem[word_addr];
endmodule

/* logic/execute_stage.sv */
`include "core_params.svh"

module execute_stage (
    ex_bus_if.sink           bus,
    input  logic             i_mem_fwd_we,
    input  logic [4:0]       i_mem_fwd_rd,
    input  logic [`XLEN-1:0] i_mem_fwd_data,
    input  logic             i_wb_fwd_we,
    input  logic [4:0]       i_wb_fwd_rd,
    input  logic [`XLEN-1:0] i_wb_fwd_data,
    output logic [`XLEN-1:0] o_alu_result,
    output logic [`XLEN-1:0] o_write_data,
    output logic [4:0]       o_rd,
    output core_pkg::ctrl_t  o_ctrl
);
    import core_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_fwd;
    logic [`XLEN-1:0] op_b;

    // Youngest producer wins
    function automatic logic [`XLEN-1:0] forward(
        input logic [4:0]       rs,
        input logic [`XLEN-1:0] reg_data
    );
        if (rs != 5'd0 && i_mem_fwd_we && i_mem_fwd_rd == rs)
            return i_mem_fwd_data;
        if (rs != 5'd0 && i_wb_fwd_we && i_wb_fwd_rd == rs)
            return i_wb_fwd_data;
        return reg_data;
    endfunction

    always_comb
    begin
        op_a    = forward(bus.rs1, bus.rs1_data);
        rs2_fwd = forward(bus.rs2, bus.rs2_data);
    end

    assign op_b = bus.ctrl.alu_src ? bus.imm : rs2_fwd;

    always_comb
    begin
        case (bus.alu_op)
            ALU_ADD: o_alu_result = op_a + op_b;
            ALU_SUB: o_alu_result = op_a - op_b;
            ALU_AND: o_alu_result = op_a & op_b;
            ALU_OR:  o_alu_result = op_a | op_b;
            ALU_XOR: o_alu_result = op_a ^ op_b;
            ALU_SLT: o_alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: o_alu_result = op_a + op_b;
        endcase
    end

    // Store data needs the forwarded rs2 too
    assign o_write_data = rs2_fwd;
    assign o_rd         = bus.rd;
    assign o_ctrl       = bus.ctrl;
endmodule

/* logic/instr_decoder.sv */
`include "core_params.svh"

module instr_decoder (
    input  core_pkg::instr_u  i_instruction,
    output logic [4:0]        o_rs1,
    output logic [4:0]        o_rs2,
    output logic [4:0]        o_rd,
    output logic [`XLEN-1:0]  o_imm,
    output core_pkg::alu_op_e o_alu_op,
    output core_pkg::ctrl_t   o_ctrl
);
    import core_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign o_rs1  = i_instruction.r_view.rs1;
    assign o_rs2  = i_instruction.r_view.rs2;
    assign o_rd   = i_instruction.r_view.rd;
    assign funct3 = i_instruction.r_view.funct3;
    assign funct7 = i_instruction.r_view.funct7;

    // Sign-extended immediate with the S-type low bits taken from the rd slot
    always_comb
    begin
        if (i_instruction.is_view.opcode == STORE)
        begin
            o_imm = {{(`XLEN-12){i_instruction.is_view.imm_hi[6]}},
                     i_instruction.is_view.imm_hi, i_instruction.is_view.rd_or_imm_lo};
        end
        else
        begin
            o_imm = {{(`XLEN-12){i_instruction.is_view.imm_hi[6]}},
                     i_instruction.is_view.imm_hi, i_instruction.is_view.rs2_or_imm_lo};
        end
    end

    // Anything not recognized falls through as a bubble
    always_comb
    begin
        o_alu_op = ALU_ADD;
        o_ctrl   = '0;
        case (i_instruction.r_view.opcode)
            OP:
            begin
                o_ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: o_alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: o_alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: o_alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: o_alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: o_alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: o_alu_op = ALU_SLT;
                    default:              o_ctrl.reg_write = 1'b0;
                endcase
            end
            OP_IMM:
            begin
                // ADDI only
                o_ctrl.reg_write = (funct3 == 3'b000);
                o_ctrl.alu_src   = 1'b1;
            end
            LOAD:
            begin
                o_ctrl.reg_write = (funct3 == 3'b010);
                o_ctrl.mem2reg   = (funct3 == 3'b010);
                o_ctrl.alu_src   = 1'b1;
            end
            STORE:
            begin
                o_ctrl.mem_write = (funct3 == 3'b010);
                o_ctrl.alu_src   = 1'b1;
            end
            default:
            begin
                o_ctrl = '0;
            end
        endcase
    end
endmodule

/* logic/pipe_regs.sv */
`include "core_params.svh"

module if_id (
    input  logic             clk,
    input  logic             i_rst,
    input  logic             i_valid,
    input  logic [31:0]      i_instruction,
    output core_pkg::instr_u o_instruction
);
    import core_pkg::*;

    // Idle cycles become bubbles
    always_ff @(posedge clk)
    begin
        if (i_rst || !i_valid)
        begin
            o_instruction <= NOOP;
        end
        else
        begin
            o_instruction <= instr_u'(i_instruction);
        end
    end
endmodule

module id_ex (
    input  logic              clk,
    input  logic              i_rst,
    input  logic [`XLEN-1:0]  i_rs1_data,
    input  logic [`XLEN-1:0]  i_rs2_data,
    input  logic [`XLEN-1:0]  i_imm,
    input  logic [4:0]        i_rs1,
    input  logic [4:0]        i_rs2,
    input  logic [4:0]        i_rd,
    input  core_pkg::alu_op_e i_alu_op,
    input  core_pkg::ctrl_t   i_ctrl,
    ex_bus_if.source          bus
);
    always_ff @(posedge clk)
    begin
        bus.rs1_data <= i_rs1_data;
        bus.rs2_data <= i_rs2_data;
        bus.imm      <= i_imm;
        bus.rs1      <= i_rs1;
        bus.rs2      <= i_rs2;
        bus.rd       <= i_rd;
        bus.alu_op   <= i_alu_op;
        if (i_rst)
        begin
            bus.ctrl <= '0;
        end
        else
        begin
            bus.ctrl <= i_ctrl;
        end
    end
endmodule

module ex_mem (
    input  logic             clk,
    input  logic             i_rst,
    input  logic [`XLEN-1:0] i_alu_result,
    input  logic [`XLEN-1:0] i_write_data,
    input  logic [4:0]       i_rd,
    input  core_pkg::ctrl_t  i_ctrl,
    mem_bus_if.source        bus
);
    always_ff @(posedge clk)
    begin
        bus.alu_result <= i_alu_result;
        bus.write_data <= i_write_data;
        bus.rd         <= i_rd;
        if (i_rst)
        begin
            bus.ctrl <= '0;
        end
        else
        begin
            bus.ctrl <= i_ctrl;
        end
    end
endmodule

module mem_wb (
    input  logic             clk,
    input  logic             i_rst,
    mem_bus_if.sink          bus,
    input  logic [`XLEN-1:0] i_mem_data,
    output logic             o_wb_reg_write,
    output logic [4:0]       o_wb_rd,
    output logic [`XLEN-1:0] o_wb_data
);
    logic [`XLEN-1:0] alu_result_q;
    logic [`XLEN-1:0] mem_data_q;
    logic             mem2reg_q;

    always_ff @(posedge clk)
    begin
        alu_result_q <= bus.alu_result;
        mem_data_q   <= i_mem_data;
        o_wb_rd      <= bus.rd;
        if (i_rst)
        begin
            mem2reg_q      <= 1'b0;
            o_wb_reg_write <= 1'b0;
        end
        else
        begin
            mem2reg_q      <= bus.ctrl.mem2reg;
            o_wb_reg_write <= bus.ctrl.reg_write;
        end
    end

    // Loads write back memory data
    assign o_wb_data = mem2reg_q ? mem_data_q : alu_result_q;
endmodule

/* logic/reg_file.sv */
`include "core_params.svh"

module reg_file (
    input  logic             clk,
    input  logic             i_rst,
    input  logic [4:0]       i_rs1,
    input  logic [4:0]       i_rs2,
    output logic [`XLEN-1:0] o_rs1_data,
    output logic [`XLEN-1:0] o_rs2_data,
    input  logic             i_we,
    input  logic [4:0]       i_rd,
    input  logic [`XLEN-1:0] i_wd
);
    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_we && i_rd != 5'd0)
        begin
            regs[i_rd] <= i_wd;
        end
    end

    // Write-through so decode sees a value written this cycle
    always_comb
    begin
        o_rs1_data = regs[i_rs1];
        o_rs2_data = regs[i_rs2];
        if (i_we && i_rd != 5'd0 && i_rd == i_rs1)
            o_rs1_data = i_wd;
        if (i_we && i_rd != 5'd0 && i_rd == i_rs2)
            o_rs2_data = i_wd;
        if (i_rs1 == 5'd0)
            o_rs1_data = '0;
        if (i_rs2 == 5'd0)
            o_rs2_data = '0;
    end
endmodule

/* logic/rv_core_top.sv */
`include "core_params.svh"

module rv_core_top (
    input  logic             clk,
    input  logic             i_rst,
    input  logic             i_valid,
    input  logic [31:0]      i_instruction,
    output logic             o_wb_valid,
    output logic [4:0]       o_wb_rd,
    output logic [`XLEN-1:0] o_wb_data
);
    import core_pkg::*;

    instr_u           id_instr;
    logic [4:0]       id_rs1;
    logic [4:0]       id_rs2;
    logic [4:0]       id_rd;
    logic [`XLEN-1:0] id_imm;
    logic [`XLEN-1:0] id_rs1_data;
    logic [`XLEN-1:0] id_rs2_data;
    alu_op_e          id_alu_op;
    ctrl_t            id_ctrl;

    logic [`XLEN-1:0] ex_alu_result;
    logic [`XLEN-1:0] ex_write_data;
    logic [4:0]       ex_rd;
    ctrl_t            ex_ctrl;

    logic [`XLEN-1:0] mem_rd_data;
    logic             wb_reg_write;

    ex_bus_if  ex_bus ();
    mem_bus_if mem_bus ();

    if_id u_if_id (.clk, .i_rst, .i_valid, .i_instruction, .o_instruction(id_instr));

    instr_decoder u_decoder (
        .i_instruction(id_instr), .o_rs1(id_rs1), .o_rs2(id_rs2), .o_rd(id_rd),
        .o_imm(id_imm), .o_alu_op(id_alu_op), .o_ctrl(id_ctrl)
    );

    reg_file u_reg_file (
        .clk, .i_rst, .i_rs1(id_rs1), .i_rs2(id_rs2),
        .o_rs1_data(id_rs1_data), .o_rs2_data(id_rs2_data),
        .i_we(wb_reg_write), .i_rd(o_wb_rd), .i_wd(o_wb_data)
    );

    id_ex u_id_ex (
        .clk, .i_rst, .i_rs1_data(id_rs1_data), .i_rs2_data(id_rs2_data), .i_imm(id_imm),
        .i_rs1(id_rs1), .i_rs2(id_rs2), .i_rd(id_rd), .i_alu_op(id_alu_op),
        .i_ctrl(id_ctrl), .bus(ex_bus.source)
    );

    // Forward paths from EX/MEM and MEM/WB
    execute_stage u_execute (
        .bus(ex_bus.sink),
        .i_mem_fwd_we(mem_bus.ctrl.reg_write), .i_mem_fwd_rd(mem_bus.rd),
        .i_mem_fwd_data(mem_bus.alu_result),
        .i_wb_fwd_we(wb_reg_write), .i_wb_fwd_rd(o_wb_rd), .i_wb_fwd_data(o_wb_data),
        .o_alu_result(ex_alu_result), .o_write_data(ex_write_data),
        .o_rd(ex_rd), .o_ctrl(ex_ctrl)
    );

    ex_mem u_ex_mem (
        .clk, .i_rst, .i_alu_result(ex_alu_result), .i_write_data(ex_write_data),
        .i_rd(ex_rd), .i_ctrl(ex_ctrl), .bus(mem_bus.source)
    );

    data_mem u_data_mem (.clk, .i_rst, .bus(mem_bus.sink), .o_rd_data(mem_rd_data));

    mem_wb u_mem_wb (
        .clk, .i_rst, .bus(mem_bus.sink), .i_mem_data(mem_rd_data),
        .o_wb_reg_write(wb_reg_write), .o_wb_rd, .o_wb_data
    );

    // Writes to x0 are not reported
    assign o_wb_valid = wb_reg_write && (o_wb_rd != 5'd0);
endmodule

/* test/core_stimulus.txt */
# I <instruction hex>, one per line in program order
# E <rd decimal> <expected writeback data hex>, in program order
I 00500093
E 1 00000005
I ffd00113
E 2 fffffffd
I 002081b3
E 3 00000002
I 40118233
E 4 fffffffd
I 001272b3
E 5 00000005
I 00316333
E 6 ffffffff
I 005343b3
E 7 fffffffa
I 00112433
E 8 00000001
I 0020a4b3
E 9 00000000
I 00108033
I 12300513
E 10 00000123
I 00a02423
I 00702623
I 00802583
E 11 00000123
I 00c02603
E 12 fffffffa
I fff08713
E 14 00000004
I 00c586b3
E 13 0000011d

/* test/tb_clock.sv */
module tb_clock (
    output logic clk
);
    // Period of 4 time units
    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end
endmodule

/* test/tb_core.sv */
module tb_core;
    logic        clk;
    logic        i_rst;
    logic        i_valid;
    logic [31:0] i_instruction;
    logic        o_wb_valid;
    logic [4:0]  o_wb_rd;
    logic [31:0] o_wb_data;

    logic [31:0] instr_q[$];
    logic [4:0]  exp_rd[$];
    logic [31:0] exp_data[$];
    logic [4:0]  want_rd;
    logic [31:0] want_data;
    logic [31:0] rng = 32'h9bafea02;
    int          n_instr = 0;
    int          cycle = 0;
    int          issued = 0;
    int          first_issue = 0;
    bit          latency_checked = 1'b0;
    int          value_errors = 0;
    int          other_errors = 0;

    tb_clock u_clock (.clk);

    rv_core_top u_dut (
        .clk, .i_rst, .i_valid, .i_instruction, .o_wb_valid, .o_wb_rd, .o_wb_data
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_and_finish;
        int total;
        total = value_errors + other_errors + exp_rd.size();
        $display("Errors: %0d value mismatches, %0d other failures, %0d writebacks never seen",
                 value_errors, other_errors, exp_rd.size());
        if (total == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    endtask

    // Stimulus, reset and program issue
    initial
    begin
        int           fd;
        int           n;
        int           rd_val;
        logic [63:0]  tag;
        logic [31:0]  word;
        logic [1023:0] rest;
        i_rst         = 1'b1;
        i_valid       = 1'b0;
        i_instruction = '0;
        fd = $fopen("test/core_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open test/core_stimulus.txt for reading");
            other_errors++;
        end
        else
        begin
            while ($fscanf(fd, "%s", tag) == 1)
            begin
                if (tag == "I")
                begin
                    n = $fscanf(fd, "%h", word);
                    if (n == 1)
                    begin
                        instr_q.push_back(word);
                    end
                    else
                    begin
                        $display("An instruction line in the stimulus file could not be read");
                        other_errors++;
                    end
                end
                else if (tag == "E")
                begin
                    n = $fscanf(fd, "%d %h", rd_val, word);
                    if (n == 2)
                    begin
                        exp_rd.push_back(rd_val[4:0]);
                        exp_data.push_back(word);
                    end
                    else
                    begin
                        $display("An expected writeback line in the stimulus file could not be read");
                        other_errors++;
                    end
                end
                else
                    n = $fgets(rest, fd);
            end
            $fclose(fd);
        end
        n_instr = instr_q.size();
        repeat (16) @(negedge clk);
        i_rst = 1'b0;
        // A few bubbles before the program starts
        repeat (4) @(negedge clk);
        while (instr_q.size() > 0)
        begin
            i_valid       = 1'b1;
            i_instruction = instr_q.pop_front();
            if (issued == 0)
                first_issue = cycle + 1;
            issued++;
            @(negedge clk);
            i_valid = 1'b0;
            rng = xorshift32(rng);
            repeat (rng % 3) @(negedge clk);
        end
        while (exp_rd.size() != 0)
            @(negedge clk);
        // Drain so a stray late writeback is still caught
        repeat (8) @(negedge clk);
        report_and_finish();
    end

    // Writeback checker
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle > 1 && issued == 0)
        begin
            assert (o_wb_valid == 1'b0)
            else
            begin
                $display("[FAIL] o_wb_valid: got %h expected %h", o_wb_valid, 1'b0);
                value_errors++;
            end
        end
        if (o_wb_valid)
        begin
            if (!latency_checked)
            begin
                assert (cycle - first_issue == 4)
                else
                begin
                    $display("[FAIL] o_wb_valid latency: got %h expected %h",
                             cycle - first_issue, 4);
                    value_errors++;
                end
                latency_checked = 1'b1;
            end
            assert (exp_rd.size() > 0)
            else
            begin
                $display("Writeback to x%0d arrived when no more writebacks were expected",
                         o_wb_rd);
                other_errors++;
            end
            if (exp_rd.size() > 0)
            begin
                want_rd   = exp_rd.pop_front();
                want_data = exp_data.pop_front();
                assert (o_wb_rd == want_rd)
                else
                begin
                    $display("[FAIL] o_wb_rd: got %h expected %h", o_wb_rd, want_rd);
                    value_errors++;
                end
                assert (o_wb_data == want_data)
                else
                begin
                    $display("[FAIL] o_wb_data: got %h expected %h", o_wb_data, want_data);
                    value_errors++;
                end
            end
        end
    end

    // Watchdog with a budget of three cycles per instruction plus margin
    initial
    begin
        @(negedge i_rst);
        repeat (n_instr * 3 + 40) @(posedge clk);
        $display("Timeout: the program did not complete within %0d cycles after reset",
                 n_instr * 3 + 40);
        other_errors++;
        report_and_finish();
    end
endmodule
